//--- source/cpu51_pkg.sv
package cpu51_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [15:0] dptr_t;

   typedef enum logic [2:0] {
      FETCH,
      DECODE0,
      DECODE1,
      DECODE2,
      EXECUTE
   } cpu_state_e;

   // one entry per supported instruction
   typedef enum logic [4:0] {
      K_NOP,
      K_MOV_AI, K_ADD_AI, K_ADDC_AI, K_SUBB_AI, K_XRL_AI,
      K_INC_A, K_DEC_A, K_CLR_A, K_CPL_A, K_RLC_A,
      K_ADD_AR, K_MOV_AR, K_MOV_RA, K_MOV_RI, K_INC_R, K_DEC_R,
      K_CLR_C, K_SETB_C,
      K_SJMP, K_JC, K_JNC, K_JZ, K_JNZ, K_CJNE, K_LJMP,
      K_MOV_DP, K_MOVX_WR, K_MOVX_RD
   } op_kind_e;

   typedef struct packed {
      logic     exec;       // one cycle in EXECUTE
      op_kind_e kind;
      reg_idx_t rn;         // opcode bits 2:0
      byte_t    op1;        // second code byte
      byte_t    op2;        // third code byte
      logic     byte_step;  // code byte consumed and pc moves on
   } ctl_t;

   typedef struct packed {
      logic carry;
      logic acc_zero;
   } flags_t;

   //////////////////////////////////////////////////////////////////////
   // opcodes as full bytes
   localparam byte_t OPC_MOV_AI  = 8'h74;
   localparam byte_t OPC_ADD_AI  = 8'h24;
   localparam byte_t OPC_ADDC_AI = 8'h34;
   localparam byte_t OPC_SUBB_AI = 8'h94;
   localparam byte_t OPC_XRL_AI  = 8'h64;
   localparam byte_t OPC_INC_A   = 8'h04;
   localparam byte_t OPC_DEC_A   = 8'h14;
   localparam byte_t OPC_CLR_A   = 8'hE4;
   localparam byte_t OPC_CPL_A   = 8'hF4;
   localparam byte_t OPC_RLC_A   = 8'h33;
   localparam byte_t OPC_CLR_C   = 8'hC3;
   localparam byte_t OPC_SETB_C  = 8'hD3;
   localparam byte_t OPC_SJMP    = 8'h80;
   localparam byte_t OPC_JC      = 8'h40;
   localparam byte_t OPC_JNC     = 8'h50;
   localparam byte_t OPC_JZ      = 8'h60;
   localparam byte_t OPC_JNZ     = 8'h70;
   localparam byte_t OPC_LJMP    = 8'h02;
   localparam byte_t OPC_MOV_DP  = 8'h90;
   localparam byte_t OPC_MOVX_WR = 8'hF0;  // movx @dptr,a
   localparam byte_t OPC_MOVX_RD = 8'hE0;  // movx a,@dptr

   // register forms by their upper five bits
   localparam logic [4:0] OPC_ADD_AR  = 5'h05;
   localparam logic [4:0] OPC_MOV_AR  = 5'h1D;
   localparam logic [4:0] OPC_MOV_RA  = 5'h1F;
   localparam logic [4:0] OPC_MOV_RI  = 5'h0F;
   localparam logic [4:0] OPC_INC_R   = 5'h01;
   localparam logic [4:0] OPC_DEC_R   = 5'h03;
   localparam logic [4:0] OPC_CJNE_RI = 5'h17;

   localparam dptr_t TX_DATA_ADDR = 16'h0201;
   localparam dptr_t TX_STAT_ADDR = 16'h0200;  // bit 0 is tx busy

endpackage

//--- source/uart_loader.sv
module uart_loader #(
   parameter int BIT_PERIOD = 104,
   parameter int CODE_AW    = 9
) (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_uart_rx,
   input  logic [CODE_AW-1:0]   i_pc,
   output logic                 o_load_done,
   output logic                 o_code_wr,
   output logic [CODE_AW-1:0]   o_code_addr,
   output cpu51_pkg::byte_t     o_code_data
);

   localparam int CW = $clog2(BIT_PERIOD);

   logic               rx_meta;
   logic               rx_sync;
   logic               active;     // inside a frame
   logic [CW-1:0]      cnt;
   logic [3:0]         bit_idx;    // 0 start, 1..8 data, 9 stop
   cpu51_pkg::byte_t   shreg;
   logic [CODE_AW-1:0] byte_cnt;
   logic               load_done;
   logic               bit_end;
   logic               sample;

   assign bit_end = (cnt == CW'(BIT_PERIOD - 1));
   assign sample  = active && (cnt == CW'(BIT_PERIOD / 2));  // mid bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_uart_rx;
         rx_sync <= rx_meta;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // frame timing
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         active  <= 1'b0;
         cnt     <= '0;
         bit_idx <= '0;
      end else if (!active) begin
         cnt     <= '0;
         bit_idx <= '0;
         active  <= !rx_sync;  // line dropped for a start bit
      end else begin
         cnt <= bit_end ? '0 : cnt + 1'b1;
         if (bit_end)
            bit_idx <= bit_idx + 4'd1;
         // false start or stop bit reached
         if (sample && ((bit_idx == 4'd0 && rx_sync) || bit_idx == 4'd9))
            active <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (sample && bit_idx != 4'd0 && bit_idx != 4'd9)
         shreg <= {rx_sync, shreg[7:1]};  // lsb arrives first
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         byte_cnt  <= '0;
         load_done <= 1'b0;
      end else if (o_code_wr) begin
         byte_cnt <= byte_cnt + 1'b1;
         if (&byte_cnt)
            load_done <= 1'b1;  // last location written
      end
   end

   assign o_code_wr   = sample && (bit_idx == 4'd9) && !load_done;
   assign o_code_addr = load_done ? i_pc : byte_cnt;
   assign o_code_data = shreg;
   assign o_load_done = load_done;

endmodule

//--- source/uart_tx.sv
module uart_tx #(
   parameter int BIT_PERIOD = 104
) (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_tx_start,
   input  cpu51_pkg::byte_t   i_tx_byte,
   output logic               o_tx_busy,
   output logic               o_uart_tx
);

   localparam int CW = $clog2(BIT_PERIOD);

   logic [CW-1:0] bit_timer;
   logic [3:0]    bit_cnt;
   logic [9:0]    frame;      // stop, data, start
   logic          busy;
   logic          bit_end;

   assign bit_end = (bit_timer == CW'(BIT_PERIOD - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy      <= 1'b0;
         bit_timer <= '0;
         bit_cnt   <= '0;
      end else if (!busy) begin
         bit_timer <= '0;
         bit_cnt   <= '0;
         busy      <= i_tx_start;
      end else if (bit_end) begin
         bit_timer <= '0;
         bit_cnt   <= bit_cnt + 4'd1;
         if (bit_cnt == 4'd9)
            busy <= 1'b0;  // stop bit done
      end else begin
         bit_timer <= bit_timer + 1'b1;
      end
   end

   // start requests while busy are lost
   always_ff @(posedge i_clk) begin
      if (i_tx_start && !busy)
         frame <= {1'b1, i_tx_byte, 1'b0};
      else if (busy && bit_end)
         frame <= {1'b1, frame[9:1]};
   end

   assign o_uart_tx = busy ? frame[0] : 1'b1;  // idle high
   assign o_tx_busy = busy;

endmodule

//--- source/cpu_control.sv
module cpu_control (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_load_done,
   input  cpu51_pkg::byte_t   i_code_data,
   output cpu51_pkg::ctl_t    o_ctl
);

   cpu51_pkg::cpu_state_e state;
   cpu51_pkg::cpu_state_e state_next;
   cpu51_pkg::byte_t      opcode_q;
   cpu51_pkg::byte_t      op1_q;
   cpu51_pkg::byte_t      op2_q;
   cpu51_pkg::byte_t      opcode;
   cpu51_pkg::op_kind_e   kind;
   logic [1:0]            nbytes;

   function automatic cpu51_pkg::op_kind_e classify(cpu51_pkg::byte_t op);
      cpu51_pkg::op_kind_e k;
      case (op)
         cpu51_pkg::OPC_MOV_AI:  k = cpu51_pkg::K_MOV_AI;
         cpu51_pkg::OPC_ADD_AI:  k = cpu51_pkg::K_ADD_AI;
         cpu51_pkg::OPC_ADDC_AI: k = cpu51_pkg::K_ADDC_AI;
         cpu51_pkg::OPC_SUBB_AI: k = cpu51_pkg::K_SUBB_AI;
         cpu51_pkg::OPC_XRL_AI:  k = cpu51_pkg::K_XRL_AI;
         cpu51_pkg::OPC_INC_A:   k = cpu51_pkg::K_INC_A;
         cpu51_pkg::OPC_DEC_A:   k = cpu51_pkg::K_DEC_A;
         cpu51_pkg::OPC_CLR_A:   k = cpu51_pkg::K_CLR_A;
         cpu51_pkg::OPC_CPL_A:   k = cpu51_pkg::K_CPL_A;
         cpu51_pkg::OPC_RLC_A:   k = cpu51_pkg::K_RLC_A;
         cpu51_pkg::OPC_CLR_C:   k = cpu51_pkg::K_CLR_C;
         cpu51_pkg::OPC_SETB_C:  k = cpu51_pkg::K_SETB_C;
         cpu51_pkg::OPC_SJMP:    k = cpu51_pkg::K_SJMP;
         cpu51_pkg::OPC_JC:      k = cpu51_pkg::K_JC;
         cpu51_pkg::OPC_JNC:     k = cpu51_pkg::K_JNC;
         cpu51_pkg::OPC_JZ:      k = cpu51_pkg::K_JZ;
         cpu51_pkg::OPC_JNZ:     k = cpu51_pkg::K_JNZ;
         cpu51_pkg::OPC_LJMP:    k = cpu51_pkg::K_LJMP;
         cpu51_pkg::OPC_MOV_DP:  k = cpu51_pkg::K_MOV_DP;
         cpu51_pkg::OPC_MOVX_WR: k = cpu51_pkg::K_MOVX_WR;
         cpu51_pkg::OPC_MOVX_RD: k = cpu51_pkg::K_MOVX_RD;
         default: begin
            case (op[7:3])  // Rn forms
               cpu51_pkg::OPC_ADD_AR:  k = cpu51_pkg::K_ADD_AR;
               cpu51_pkg::OPC_MOV_AR:  k = cpu51_pkg::K_MOV_AR;
               cpu51_pkg::OPC_MOV_RA:  k = cpu51_pkg::K_MOV_RA;
               cpu51_pkg::OPC_MOV_RI:  k = cpu51_pkg::K_MOV_RI;
               cpu51_pkg::OPC_INC_R:   k = cpu51_pkg::K_INC_R;
               cpu51_pkg::OPC_DEC_R:   k = cpu51_pkg::K_DEC_R;
               cpu51_pkg::OPC_CJNE_RI: k = cpu51_pkg::K_CJNE;
               default:                k = cpu51_pkg::K_NOP;
            endcase
         end
      endcase
      return k;
   endfunction

   function automatic logic [1:0] byte_count(cpu51_pkg::op_kind_e k);
      case (k)
         cpu51_pkg::K_CJNE, cpu51_pkg::K_LJMP, cpu51_pkg::K_MOV_DP:
            return 2'd3;
         cpu51_pkg::K_MOV_AI, cpu51_pkg::K_ADD_AI, cpu51_pkg::K_ADDC_AI,
         cpu51_pkg::K_SUBB_AI, cpu51_pkg::K_XRL_AI, cpu51_pkg::K_MOV_RI,
         cpu51_pkg::K_SJMP, cpu51_pkg::K_JC, cpu51_pkg::K_JNC,
         cpu51_pkg::K_JZ, cpu51_pkg::K_JNZ:
            return 2'd2;
         default:
            return 2'd1;
      endcase
   endfunction

   // opcode straight off the bus in DECODE0, so the byte count is known there
   assign opcode = (state == cpu51_pkg::DECODE0) ? i_code_data : opcode_q;
   assign kind   = classify(opcode);
   assign nbytes = byte_count(kind);

   always_comb begin
      state_next = state;
      case (state)
         cpu51_pkg::FETCH:   if (i_load_done) state_next = cpu51_pkg::DECODE0;
         cpu51_pkg::DECODE0: state_next = (nbytes > 2'd1) ? cpu51_pkg::DECODE1
                                                          : cpu51_pkg::EXECUTE;
         cpu51_pkg::DECODE1: state_next = (nbytes > 2'd2) ? cpu51_pkg::DECODE2
                                                          : cpu51_pkg::EXECUTE;
         cpu51_pkg::DECODE2: state_next = cpu51_pkg::EXECUTE;
         default:            state_next = cpu51_pkg::FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= cpu51_pkg::FETCH;
         opcode_q <= '0;  // decodes as nop
      end else begin
         state <= state_next;
         if (state == cpu51_pkg::DECODE0)
            opcode_q <= i_code_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == cpu51_pkg::DECODE1)
         op1_q <= i_code_data;
      if (state == cpu51_pkg::DECODE2)
         op2_q <= i_code_data;
   end

   always_comb begin
      o_ctl.exec      = (state == cpu51_pkg::EXECUTE);
      o_ctl.kind      = kind;
      o_ctl.rn        = opcode[2:0];
      o_ctl.op1       = op1_q;
      o_ctl.op2       = op2_q;
      o_ctl.byte_step = (state == cpu51_pkg::DECODE0) || (state == cpu51_pkg::DECODE1) ||
                        (state == cpu51_pkg::DECODE2);
   end

endmodule

//--- source/pc_unit.sv
module pc_unit #(
   parameter int CODE_AW = 9
) (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  cpu51_pkg::ctl_t      i_ctl,
   input  cpu51_pkg::flags_t    i_flags,
   input  cpu51_pkg::byte_t     i_rn_val,
   output logic [CODE_AW-1:0]   o_pc
);

   logic [CODE_AW-1:0] pc;
   logic               taken;
   cpu51_pkg::byte_t   rel;
   logic [15:0]        target;    // pc plus signed offset
   logic [15:0]        long_addr;

   always_comb begin
      taken = 1'b0;
      rel   = i_ctl.op1;
      case (i_ctl.kind)
         cpu51_pkg::K_SJMP: taken = 1'b1;
         cpu51_pkg::K_JC:   taken = i_flags.carry;
         cpu51_pkg::K_JNC:  taken = !i_flags.carry;
         cpu51_pkg::K_JZ:   taken = i_flags.acc_zero;
         cpu51_pkg::K_JNZ:  taken = !i_flags.acc_zero;
         cpu51_pkg::K_CJNE: begin
            taken = (i_rn_val != i_ctl.op1);
            rel   = i_ctl.op2;  // offset is the third byte
         end
         default: taken = 1'b0;
      endcase
   end

   // pc already points past the instruction in EXECUTE
   assign target    = 16'(pc) + {{8{rel[7]}}, rel};
   assign long_addr = {i_ctl.op1, i_ctl.op2};

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         pc <= '0;
      else if (i_ctl.byte_step)
         pc <= pc + 1'b1;
      else if (i_ctl.exec && i_ctl.kind == cpu51_pkg::K_LJMP)
         pc <= long_addr[CODE_AW-1:0];
      else if (i_ctl.exec && taken)
         pc <= target[CODE_AW-1:0];
   end

   assign o_pc = pc;

endmodule

//--- source/reg_file.sv
module reg_file (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  cpu51_pkg::ctl_t    i_ctl,
   input  cpu51_pkg::byte_t   i_acc,
   output cpu51_pkg::byte_t   o_rn_val
);

   cpu51_pkg::byte_t regs [8];  // r0..r7

   assign o_rn_val = regs[i_ctl.rn];

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
      end else if (i_ctl.exec) begin
         case (i_ctl.kind)
            cpu51_pkg::K_MOV_RA: regs[i_ctl.rn] <= i_acc;
            cpu51_pkg::K_MOV_RI: regs[i_ctl.rn] <= i_ctl.op1;
            cpu51_pkg::K_INC_R:  regs[i_ctl.rn] <= o_rn_val + 8'd1;
            cpu51_pkg::K_DEC_R:  regs[i_ctl.rn] <= o_rn_val - 8'd1;
            default: ;
         endcase
      end
   end

endmodule

//--- source/exec_unit.sv
module exec_unit (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  cpu51_pkg::ctl_t    i_ctl,
   input  cpu51_pkg::byte_t   i_rn_val,
   input  logic               i_tx_busy,
   output cpu51_pkg::byte_t   o_acc,
   output cpu51_pkg::flags_t  o_flags,
   output logic               o_tx_start,
   output cpu51_pkg::byte_t   o_tx_byte
);

   cpu51_pkg::byte_t acc;
   cpu51_pkg::byte_t acc_next;
   logic             carry;
   logic             carry_next;
   cpu51_pkg::dptr_t dptr;
   cpu51_pkg::byte_t addend;
   logic             cin;
   logic [8:0]       sum;   // bit 8 is carry out
   logic [8:0]       diff;  // bit 8 is borrow

   assign addend = (i_ctl.kind == cpu51_pkg::K_ADD_AR) ? i_rn_val : i_ctl.op1;
   assign cin    = (i_ctl.kind == cpu51_pkg::K_ADDC_AI) && carry;
   assign sum    = {1'b0, acc} + {1'b0, addend} + 9'(cin);
   assign diff   = {1'b0, acc} - {1'b0, i_ctl.op1} - 9'(carry);

   //////////////////////////////////////////////////////////////////////
   // accumulator and carry
   always_comb begin
      acc_next   = acc;
      carry_next = carry;
      case (i_ctl.kind)
         cpu51_pkg::K_MOV_AI: acc_next = i_ctl.op1;
         cpu51_pkg::K_ADD_AI, cpu51_pkg::K_ADDC_AI, cpu51_pkg::K_ADD_AR: begin
            acc_next   = sum[7:0];
            carry_next = sum[8];
         end
         cpu51_pkg::K_SUBB_AI: begin
            acc_next   = diff[7:0];
            carry_next = diff[8];
         end
         cpu51_pkg::K_XRL_AI: acc_next = acc ^ i_ctl.op1;
         cpu51_pkg::K_INC_A:  acc_next = acc + 8'd1;  // no flags
         cpu51_pkg::K_DEC_A:  acc_next = acc - 8'd1;
         cpu51_pkg::K_CLR_A:  acc_next = '0;
         cpu51_pkg::K_CPL_A:  acc_next = ~acc;
         cpu51_pkg::K_RLC_A: begin
            acc_next   = {acc[6:0], carry};
            carry_next = acc[7];
         end
         cpu51_pkg::K_MOV_AR: acc_next = i_rn_val;
         cpu51_pkg::K_CLR_C:  carry_next = 1'b0;
         cpu51_pkg::K_SETB_C: carry_next = 1'b1;
         cpu51_pkg::K_CJNE:   carry_next = (i_rn_val < i_ctl.op1);
         // only the status address reads back something
         cpu51_pkg::K_MOVX_RD:
            acc_next = (dptr == cpu51_pkg::TX_STAT_ADDR) ? {7'd0, i_tx_busy} : '0;
         default: ;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else if (i_ctl.exec) begin
         acc   <= acc_next;
         carry <= carry_next;
         if (i_ctl.kind == cpu51_pkg::K_MOV_DP)
            dptr <= {i_ctl.op1, i_ctl.op2};  // high byte first
      end
   end

   assign o_tx_start = i_ctl.exec && (i_ctl.kind == cpu51_pkg::K_MOVX_WR) &&
                       (dptr == cpu51_pkg::TX_DATA_ADDR) && !i_tx_busy;
   assign o_tx_byte  = acc;
   assign o_acc      = acc;

   assign o_flags.carry    = carry;
   assign o_flags.acc_zero = (acc == 8'd0);

endmodule

//--- source/cpu51_top.sv
module cpu51_top #(
   parameter int BIT_PERIOD = 104,
   parameter int CODE_AW    = 9
) (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_uart_rx,
   output logic                 o_uart_tx,
   output logic                 o_code_wr,
   output logic [CODE_AW-1:0]   o_code_addr,
   output cpu51_pkg::byte_t     o_code_data,
   input  cpu51_pkg::byte_t     i_code_data
);

   logic               load_done;
   cpu51_pkg::ctl_t    ctl;
   cpu51_pkg::flags_t  flags;
   logic [CODE_AW-1:0] pc;
   cpu51_pkg::byte_t   rn_val;
   cpu51_pkg::byte_t   acc;
   cpu51_pkg::byte_t   tx_byte;
   logic               tx_start;
   logic               tx_busy;

   uart_loader #(.BIT_PERIOD(BIT_PERIOD), .CODE_AW(CODE_AW)) u_uart_loader (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx), .i_pc(pc),
      .o_load_done(load_done), .o_code_wr(o_code_wr),
      .o_code_addr(o_code_addr), .o_code_data(o_code_data)
   );

   cpu_control u_cpu_control (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_load_done(load_done),
      .i_code_data(i_code_data), .o_ctl(ctl)
   );

   pc_unit #(.CODE_AW(CODE_AW)) u_pc_unit (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_ctl(ctl), .i_flags(flags),
      .i_rn_val(rn_val), .o_pc(pc)
   );

   reg_file u_reg_file (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_ctl(ctl), .i_acc(acc), .o_rn_val(rn_val)
   );

   exec_unit u_exec_unit (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_ctl(ctl), .i_rn_val(rn_val),
      .i_tx_busy(tx_busy), .o_acc(acc), .o_flags(flags),
      .o_tx_start(tx_start), .o_tx_byte(tx_byte)
   );

   uart_tx #(.BIT_PERIOD(BIT_PERIOD)) u_uart_tx (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_tx_start(tx_start), .i_tx_byte(tx_byte),
      .o_tx_busy(tx_busy), .o_uart_tx(o_uart_tx)
   );

endmodule

//--- dv/tb_clock.sv
module tb_clock #(
   parameter int PERIOD = 40
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD / 2) o_clk = ~o_clk;
   end

endmodule

//--- dv/cpu51_props.sv
module cpu51_props (
   input logic                  i_clk,
   input logic                  i_nrst,
   input cpu51_pkg::cpu_state_e i_state,
   input logic                  i_code_wr,
   input logic                  i_load_done
);

   // one write per received byte
   a_wr_single : assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_code_wr |=> !i_code_wr)
      else $error("code write held for two cycles");

   // load done holds until reset and no write follows it
   a_no_wr_after_done : assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_load_done |=> (i_load_done && !i_code_wr))
      else $error("load done dropped or code write after load done");

   a_exec_to_fetch : assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_state == cpu51_pkg::EXECUTE) |=> (i_state == cpu51_pkg::FETCH))
      else $error("execute not followed by fetch");

endmodule

bind cpu_control cpu51_props u_ctl_props (
   .i_clk(i_clk), .i_nrst(i_nrst), .i_state(state),
   .i_code_wr(1'b0), .i_load_done(i_load_done)
);

bind uart_loader cpu51_props u_loader_props (
   .i_clk(i_clk), .i_nrst(i_nrst), .i_state(cpu51_pkg::FETCH),
   .i_code_wr(o_code_wr), .i_load_done(o_load_done)
);

//--- dv/tb_cpu51.sv
module tb_cpu51;

   localparam int BP         = 8;
   localparam int AW         = 6;
   localparam int DEPTH      = 64;
   localparam int NTEST      = 8;
   localparam int MAX_FRAMES = 5;
   localparam int LIMIT      = NTEST * (DEPTH * 10 * BP + MAX_FRAMES * 10 * BP * 4) + 2000;

   logic             clk;
   logic             nrst;
   logic             uart_rx;
   logic             uart_tx;
   logic             code_wr;
   logic [AW-1:0]    code_addr;
   cpu51_pkg::byte_t code_wdata;
   cpu51_pkg::byte_t code_rdata;

   cpu51_pkg::byte_t image [DEPTH];
   cpu51_pkg::byte_t code_mem [DEPTH];
   int               prog [$];
   int               expected [$];
   int               received [$];
   int               seed = 32'h292af23f;
   int               wr_count;
   int               errors;
   int               checks;
   int               failed;
   int               cycles;

   tb_clock #(.PERIOD(40)) u_tb_clock (.o_clk(clk));

   cpu51_top #(.BIT_PERIOD(BP), .CODE_AW(AW)) u_cpu51_top (
      .i_clk(clk), .i_nrst(nrst), .i_uart_rx(uart_rx), .o_uart_tx(uart_tx),
      .o_code_wr(code_wr), .o_code_addr(code_addr), .o_code_data(code_wdata),
      .i_code_data(code_rdata)
   );

   assign code_rdata = code_mem[code_addr];  // async read

   task automatic check_eq(input int got, input int exp, input string what);
      checks++;
      if (got != exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic int rnd(input int k);
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % k;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // code memory capture and uart monitor
   always @(negedge clk) begin
      if (nrst && code_wr) begin
         check_eq(int'(uart_tx), 1, "tx idle during load");
         check_eq(int'(code_addr), wr_count, "write address");
         if (wr_count < DEPTH)
            check_eq(int'(code_wdata), int'(image[wr_count]), "write data");
         code_mem[code_addr] = code_wdata;
         wr_count++;
      end
   end

   initial begin
      int bits [10];
      int data;
      forever begin
         @(negedge clk);
         if (nrst && !uart_tx) begin
            bits[0] = 0;  // first low sample is cycle 0 of the start bit
            for (int i = 1; i < 10 * BP; i++) begin
               @(negedge clk);
               if (i % BP == 0)
                  bits[i / BP] = int'(uart_tx);
               else
                  check_eq(int'(uart_tx), bits[i / BP], "level within bit time");
            end
            check_eq(bits[9], 1, "stop bit");
            data = 0;
            for (int b = 0; b < 8; b++)
               data = data | (bits[b + 1] << b);  // lsb first
            received.push_back(data);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("timeout, the run went past %0d cycles", LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // program builders
   task automatic tx_from_acc();
      int seq [12] = '{8'hFF, 8'h90, 8'h02, 8'h00, 8'hE0, 8'h70, 8'hFD,
                       8'hEF, 8'h90, 8'h02, 8'h01, 8'hF0};
      foreach (seq[i])
         prog.push_back(seq[i]);  // save A in r7 then poll busy and write
   endtask

   task automatic marker_frame(input int m);
      prog.push_back(8'h74);
      prog.push_back(m);
      tx_from_acc();
   endtask

   task automatic random_acc_op();
      int imm [4] = '{8'h24, 8'h34, 8'h94, 8'h64};
      int one [6] = '{8'h04, 8'h14, 8'hF4, 8'h33, 8'hC3, 8'hD3};
      int k;
      k = rnd(10);
      if (k < 4) begin
         prog.push_back(imm[k]);
         prog.push_back(rnd(256));
      end else begin
         prog.push_back(one[k - 4]);
      end
   endtask

   task automatic cond_branch_block();
      int ops [4] = '{8'h40, 8'h50, 8'h60, 8'h70};
      prog.push_back(8'h74);
      prog.push_back(rnd(2) ? 0 : rnd(256));
      prog.push_back(rnd(2) ? 8'hC3 : 8'hD3);
      prog.push_back(ops[rnd(4)]);
      prog.push_back(14);  // skip one marker
      marker_frame(8'hA0 + rnd(16));
      marker_frame(8'hB0 + rnd(16));
   endtask

   task automatic build(input int kind);
      int n;
      int top;
      case (kind)
         0: begin
            for (int i = 0; i < 4; i++)
               marker_frame(rnd(256));
         end
         1: begin
            marker_frame(rnd(256));
            for (int i = 0; i < 3; i++) begin
               random_acc_op();
               random_acc_op();
               tx_from_acc();
            end
         end
         2: begin
            marker_frame(rnd(256));
            for (int i = 0; i < 3; i++) begin
               n = rnd(7);  // r7 belongs to the transmit sequence
               prog.push_back(8'h78 | n);
               prog.push_back(rnd(256));
               case (rnd(3))
                  0: prog.push_back(8'h08 | n);
                  1: prog.push_back(8'h18 | n);
                  default: ;
               endcase
               prog.push_back(rnd(2) ? (8'hE8 | n) : (8'h28 | n));
               tx_from_acc();
            end
         end
         3: begin
            prog.push_back(8'h78);
            prog.push_back(1 + rnd(3));
            top = prog.size();
            prog.push_back(8'hE8);
            tx_from_acc();
            prog.push_back(8'h18);  // dec r0
            prog.push_back(8'hB8);
            prog.push_back(8'h00);
            prog.push_back((top - (prog.size() + 1)) & 8'hFF);
            cond_branch_block();
         end
         default: begin
            prog.push_back(8'h02);
            prog.push_back(8'h00);
            prog.push_back(prog.size() + 3);  // past the skipped mov
            prog.push_back(8'h74);
            prog.push_back(8'hEE);
            marker_frame(rnd(256));
            prog.push_back(8'h80);
            prog.push_back(2);
            prog.push_back(8'h74);
            prog.push_back(8'hEE);
            marker_frame(rnd(256));
         end
      endcase
   endtask

   task automatic pad_image();
      int i;
      for (i = 0; i < prog.size(); i++)
         image[i] = cpu51_pkg::byte_t'(prog[i]);
      if ((DEPTH - i) % 2 == 1) begin
         image[i] = 8'h00;
         i++;
      end
      while (i < DEPTH) begin
         image[i]     = 8'h80;  // sjmp to itself
         image[i + 1] = 8'hFE;
         i += 2;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // instruction set model
   task automatic predict_frames();
      int pc;
      int a;
      int c;
      int dp;
      int op;
      int b1;
      int b2;
      int n;
      int nxt;
      int rel;
      int jmp;
      int t;
      int rn;
      int steps;
      int r [8];
      pc = 0;
      a  = 0;
      c  = 0;
      dp = 0;
      foreach (r[i])
         r[i] = 0;
      expected.delete();
      for (steps = 0; steps < 4000; steps++) begin
         op  = int'(image[pc]);
         b1  = int'(image[(pc + 1) % DEPTH]);
         b2  = int'(image[(pc + 2) % DEPTH]);
         rn  = op & 7;
         if (op == 8'h80 && b1 == 8'hFE)
            break;  // parked
         n   = (op == 8'h02 || op == 8'h90 || (op >> 3) == 8'h17) ? 3 :
               (op inside {8'h74, 8'h24, 8'h34, 8'h94, 8'h64, 8'h80, 8'h40, 8'h50,
                           8'h60, 8'h70} || (op >> 3) == 8'h0F) ? 2 : 1;
         nxt = (pc + n) % DEPTH;
         rel = (n == 3) ? b2 : b1;
         rel = (rel > 127) ? rel - 256 : rel;
         jmp = -1;
         case (op)
            8'h74: a = b1;
            8'h24, 8'h34: begin
               t = a + b1 + ((op == 8'h34) ? c : 0);
               c = (t > 255);
               a = t & 255;
            end
            8'h94: begin
               t = a - b1 - c;
               c = (t < 0);
               a = t & 255;
            end
            8'h64: a = a ^ b1;
            8'h04: a = (a + 1) & 255;
            8'h14: a = (a + 255) & 255;
            8'hE4: a = 0;
            8'hF4: a = a ^ 255;
            8'h33: begin
               t = ((a << 1) | c) & 255;
               c = a >> 7;
               a = t;
            end
            8'hC3: c = 0;
            8'hD3: c = 1;
            8'h80: jmp = nxt + rel;
            8'h40: if (c) jmp = nxt + rel;
            8'h50: if (!c) jmp = nxt + rel;
            8'h60: if (a == 0) jmp = nxt + rel;
            8'h70: if (a != 0) jmp = nxt + rel;
            8'h02: jmp = ((b1 << 8) | b2);
            8'h90: dp = (b1 << 8) | b2;
            8'hF0: if (dp == 16'h0201) expected.push_back(a);
            8'hE0: a = 0;  // the model sees the transmitter idle when polled
            default: begin
               case (op >> 3)
                  8'h05: begin
                     t = a + r[rn];
                     c = (t > 255);
                     a = t & 255;
                  end
                  8'h1D: a = r[rn];
                  8'h1F: r[rn] = a;
                  8'h0F: r[rn] = b1;
                  8'h01: r[rn] = (r[rn] + 1) & 255;
                  8'h03: r[rn] = (r[rn] + 255) & 255;
                  8'h17: begin
                     c = (r[rn] < b1);
                     if (r[rn] != b1) jmp = nxt + rel;
                  end
                  default: ;
               endcase
            end
         endcase
         pc = (jmp >= 0) ? (jmp % DEPTH) : nxt;
         pc = pc & (DEPTH - 1);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus
   task automatic send_byte(input cpu51_pkg::byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         uart_rx = frame[i];
         repeat (BP - 1) @(negedge clk);
      end
   endtask

   task automatic run_test(input string name, input int kind);
      int err0;
      int budget;
      int waited;
      err0 = errors;
      prog.delete();
      build(kind);
      pad_image();
      predict_frames();
      @(negedge clk);
      nrst     = 1'b0;
      uart_rx  = 1'b1;
      repeat (4) @(negedge clk);
      wr_count = 0;
      received.delete();
      nrst     = 1'b1;
      for (int i = 0; i < DEPTH; i++)
         send_byte(image[i]);
      budget = expected.size() * 10 * BP * 3 + 200;
      waited = 0;
      while (received.size() < expected.size() && waited < budget) begin
         @(negedge clk);
         waited++;
      end
      if (received.size() < expected.size()) begin
         errors++;
         $display("test %s never sent its frames, %0d of %0d arrived",
                  name, received.size(), expected.size());
      end
      repeat (20 * BP) @(negedge clk);  // room for any extra frame
      check_eq(wr_count, DEPTH, "code write count");
      check_eq(received.size(), expected.size(), "frame count");
      for (int i = 0; i < received.size() && i < expected.size(); i++)
         check_eq(received[i], expected[i], "frame data");
      if (errors != err0)
         failed++;
      $display("test %-10s %s, %0d frames", name, (errors == err0) ? "ok" : "failed",
               expected.size());
   endtask

   initial begin
      nrst     = 1'b0;
      uart_rx  = 1'b1;
      wr_count = 0;
      errors   = 0;
      checks   = 0;
      failed   = 0;
      cycles   = 0;
      foreach (code_mem[i])
         code_mem[i] = 8'h00;
      run_test("tx_flow", 0);
      run_test("acc_a", 1);
      run_test("acc_b", 1);
      run_test("regs_a", 2);
      run_test("regs_b", 2);
      run_test("loop_a", 3);
      run_test("loop_b", 3);
      run_test("jumps", 4);
      $display("tests %0d, failed %0d, checks %0d, errors %0d", NTEST, failed, checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- project.f
source/cpu51_pkg.sv
source/uart_loader.sv
source/uart_tx.sv
source/cpu_control.sv
source/pc_unit.sv
source/reg_file.sv
source/exec_unit.sv
source/cpu51_top.sv
dv/tb_clock.sv
dv/cpu51_props.sv
dv/tb_cpu51.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_cpu51 \
		-f project.f --Mdir obj_dir -o sim_cpu51
	./obj_dir/sim_cpu51 | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
